/* source/ip_tx_pkg.sv */
`default_nettype none

package ip_tx_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ip_len_t;   // lengths and identification.
    typedef logic [7:0]  ip_byte_t;
    typedef logic [7:0]  ip_proto_t;
    typedef logic [4:0]  hdr_idx_t;  // header byte number.

    localparam ip_byte_t  IP_VER_IHL    = 8'h45;   // version 4, five words.
    localparam ip_byte_t  IP_TOS        = 8'h00;
    localparam ip_len_t   IP_FLAGS_FRAG = 16'h4000; // DF, no offset.
    localparam ip_byte_t  IP_TTL        = 8'h80;
    localparam ip_proto_t IP_PROTO_UDP  = 8'h11;
    localparam ip_proto_t IP_PROTO_ICMP = 8'h01;
    localparam int        IP_HDR_BYTES  = 20;

    // fields that differ per datagram, in header order.
    typedef struct packed {
        ip_len_t   total_len;
        ip_len_t   ident;
        ip_proto_t proto;
        ip_addr_t  src;
        ip_addr_t  dst;
    } ip_hdr_fields_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        CSUM,
        HDR,
        PAYLOAD,
        DONE
    } tx_state_t;

endpackage

`default_nettype wire

/* source/ip_tx_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module ip_tx_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 fs,
    input  wire ip_tx_pkg::ip_proto_t proto,
    input  wire logic                 fd_udp,
    input  wire logic                 fd_icmp,
    input  wire logic                 csum_valid,
    output logic                      fd,
    output ip_tx_pkg::ip_len_t        ident,
    output logic                      csum_start,
    output logic                      hdr_en,
    output ip_tx_pkg::hdr_idx_t       hdr_idx,
    output logic                      fs_udp,
    output logic                      fs_icmp
);

    localparam ip_tx_pkg::hdr_idx_t HDR_LAST = ip_tx_pkg::hdr_idx_t'(ip_tx_pkg::IP_HDR_BYTES - 1);

    ip_tx_pkg::tx_state_t state;
    logic sel_udp;   // payload source chosen in WAIT.
    logic sel_icmp;
    logic fd_sel;
    logic last_hdr;
    logic pay_run;

    assign fd_sel   = (sel_udp && fd_udp) || (sel_icmp && fd_icmp);
    assign hdr_en   = (state == ip_tx_pkg::HDR);
    assign last_hdr = hdr_en && (hdr_idx == HDR_LAST);

    // source is started on the last header cycle so its first byte
    // follows the header back to back.
    assign pay_run = (state == ip_tx_pkg::PAYLOAD) || last_hdr;
    assign fs_udp  = pay_run && sel_udp;
    assign fs_icmp = pay_run && sel_icmp;

    assign fd = (state == ip_tx_pkg::DONE) && fs;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ip_tx_pkg::IDLE;
            sel_udp    <= 1'b0;
            sel_icmp   <= 1'b0;
            hdr_idx    <= '0;
            ident      <= '0;
            csum_start <= 1'b0;
        end else begin
            csum_start <= 1'b0;
            case (state)
                ip_tx_pkg::IDLE: state <= ip_tx_pkg::WAIT;
                ip_tx_pkg::WAIT: begin
                    if (fs) begin
                        if (proto == ip_tx_pkg::IP_PROTO_UDP) begin
                            sel_udp    <= 1'b1;
                            sel_icmp   <= 1'b0;
                            csum_start <= 1'b1;
                            state      <= ip_tx_pkg::CSUM;
                        end else if (proto == ip_tx_pkg::IP_PROTO_ICMP) begin
                            sel_udp    <= 1'b0;
                            sel_icmp   <= 1'b1;
                            csum_start <= 1'b1;
                            state      <= ip_tx_pkg::CSUM;
                        end else begin
                            state <= ip_tx_pkg::DONE; // rejected, nothing sent.
                        end
                    end
                end
                ip_tx_pkg::CSUM: begin
                    if (csum_valid) begin
                        hdr_idx <= '0;
                        state   <= ip_tx_pkg::HDR;
                    end
                end
                ip_tx_pkg::HDR: begin
                    if (hdr_idx == HDR_LAST) begin
                        state <= ip_tx_pkg::PAYLOAD;
                    end else begin
                        hdr_idx <= hdr_idx + 1'b1;
                    end
                end
                ip_tx_pkg::PAYLOAD: begin
                    if (fd_sel) begin
                        ident <= ident + 1'b1; // counts sent datagrams only.
                        state <= ip_tx_pkg::DONE;
                    end
                end
                ip_tx_pkg::DONE: begin
                    if (!fs) begin
                        state <= ip_tx_pkg::WAIT;
                    end
                end
                default: state <= ip_tx_pkg::IDLE;
            endcase
        end
    end

    a_one_source: assert property (@(posedge clk) disable iff (rst) !(fs_udp && fs_icmp))
        else $error("both payload sources started");

    a_hdr_idx: assert property (@(posedge clk) disable iff (rst)
        hdr_en |-> (hdr_idx < ip_tx_pkg::hdr_idx_t'(ip_tx_pkg::IP_HDR_BYTES)))
        else $error("header index out of range");

endmodule

`default_nettype wire

/* source/ip_hdr_checksum.sv */
`timescale 1ns/1ns
`default_nettype none

module ip_hdr_checksum (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      start,
    input  wire ip_tx_pkg::ip_hdr_fields_t fields,
    output ip_tx_pkg::ip_len_t             csum,
    output logic                           valid
);

    localparam logic [3:0] FOLD_STEP = 4'd10;

    logic        busy;
    logic [3:0]  step;      // word number, FOLD_STEP on the fold cycle.
    logic [3:0]  word_idx;
    logic [15:0] word;
    logic [19:0] acc;
    logic [16:0] fold1;
    logic [15:0] fold2;

    assign word_idx = start ? 4'd0 : step;

    always_comb begin
        case (word_idx)
            4'd0: word = {ip_tx_pkg::IP_VER_IHL, ip_tx_pkg::IP_TOS};
            4'd1: word = fields.total_len;
            4'd2: word = fields.ident;
            4'd3: word = ip_tx_pkg::IP_FLAGS_FRAG;
            4'd4: word = {ip_tx_pkg::IP_TTL, fields.proto};
            4'd6: word = fields.src[31:16];
            4'd7: word = fields.src[15:0];
            4'd8: word = fields.dst[31:16];
            4'd9: word = fields.dst[15:0];
            default: word = 16'h0000; // word 5 is the checksum itself.
        endcase
    end

    // two folds absorb all carries of a ten word sum.
    assign fold1 = {1'b0, acc[15:0]} + {13'd0, acc[19:16]};
    assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            step  <= '0;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= 4'd1;
            end else if (busy) begin
                if (step == FOLD_STEP) begin
                    busy  <= 1'b0;
                    valid <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= {4'd0, word};
        end else if (busy && step != FOLD_STEP) begin
            acc <= acc + {4'd0, word};
        end
        if (busy && step == FOLD_STEP) begin
            csum <= ~fold2;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("checksum restarted while busy");

endmodule

`default_nettype wire

/* source/ip_tx_byte_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module ip_tx_byte_mux (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      hdr_en,
    input  wire ip_tx_pkg::hdr_idx_t       hdr_idx,
    input  wire ip_tx_pkg::ip_hdr_fields_t fields,
    input  wire ip_tx_pkg::ip_len_t        csum,
    input  wire logic                      pay_valid,
    input  wire ip_tx_pkg::ip_byte_t       pay_byte,
    output ip_tx_pkg::ip_byte_t            ip_txd,
    output logic                           ip_txd_en
);

    ip_tx_pkg::ip_byte_t hdr_byte;

    // header in network byte order.
    always_comb begin
        case (hdr_idx)
            5'd0:  hdr_byte = ip_tx_pkg::IP_VER_IHL;
            5'd1:  hdr_byte = ip_tx_pkg::IP_TOS;
            5'd2:  hdr_byte = fields.total_len[15:8];
            5'd3:  hdr_byte = fields.total_len[7:0];
            5'd4:  hdr_byte = fields.ident[15:8];
            5'd5:  hdr_byte = fields.ident[7:0];
            5'd6:  hdr_byte = ip_tx_pkg::IP_FLAGS_FRAG[15:8];
            5'd7:  hdr_byte = ip_tx_pkg::IP_FLAGS_FRAG[7:0];
            5'd8:  hdr_byte = ip_tx_pkg::IP_TTL;
            5'd9:  hdr_byte = fields.proto;
            5'd10: hdr_byte = csum[15:8];
            5'd11: hdr_byte = csum[7:0];
            5'd12: hdr_byte = fields.src[31:24];
            5'd13: hdr_byte = fields.src[23:16];
            5'd14: hdr_byte = fields.src[15:8];
            5'd15: hdr_byte = fields.src[7:0];
            5'd16: hdr_byte = fields.dst[31:24];
            5'd17: hdr_byte = fields.dst[23:16];
            5'd18: hdr_byte = fields.dst[15:8];
            5'd19: hdr_byte = fields.dst[7:0];
            default: hdr_byte = 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ip_txd    <= '0;
            ip_txd_en <= 1'b0;
        end else if (hdr_en) begin
            ip_txd    <= hdr_byte;
            ip_txd_en <= 1'b1;
        end else if (pay_valid) begin
            ip_txd    <= pay_byte;
            ip_txd_en <= 1'b1;
        end else begin
            ip_txd    <= '0;   // idle line reads zero.
            ip_txd_en <= 1'b0;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (rst) !(hdr_en && pay_valid))
        else $error("header and payload bytes overlap");

endmodule

`default_nettype wire

/* source/ip_payload_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module ip_payload_gen #(
    parameter ip_tx_pkg::ip_byte_t PATTERN_BASE = 8'h00
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               fs,
    input  wire ip_tx_pkg::ip_len_t total_len,
    output logic                    fd,
    output ip_tx_pkg::ip_byte_t     pay_byte,
    output logic                    pay_valid
);

    localparam ip_tx_pkg::ip_len_t HDR_LEN = ip_tx_pkg::ip_len_t'(ip_tx_pkg::IP_HDR_BYTES);

    logic                fs_q;
    ip_tx_pkg::ip_len_t  body_len;
    ip_tx_pkg::ip_len_t  remain;   // bytes left after the current one.
    ip_tx_pkg::ip_byte_t num;      // next byte number, wraps at 256.

    assign body_len = (total_len > HDR_LEN) ? total_len - HDR_LEN : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_q      <= 1'b0;
            remain    <= '0;
            num       <= '0;
            pay_byte  <= '0;
            pay_valid <= 1'b0;
            fd        <= 1'b0;
        end else begin
            fs_q <= fs;
            if (!fs) begin
                remain    <= '0;
                pay_byte  <= '0;
                pay_valid <= 1'b0;
                fd        <= 1'b0;
            end else if (!fs_q) begin
                if (body_len == '0) begin
                    fd <= 1'b1;   // header-only datagram.
                end else begin
                    pay_byte  <= PATTERN_BASE;
                    pay_valid <= 1'b1;
                    num       <= 8'd1;
                    remain    <= body_len - 1'b1;
                end
            end else if (remain != '0) begin
                pay_byte <= PATTERN_BASE + num;
                num      <= num + 1'b1;
                remain   <= remain - 1'b1;
            end else if (pay_valid) begin
                pay_byte  <= '0;
                pay_valid <= 1'b0;
                fd        <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/ip_tx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ip_tx_top #(
    parameter ip_tx_pkg::ip_byte_t UDP_PATTERN  = 8'h00,
    parameter ip_tx_pkg::ip_byte_t ICMP_PATTERN = 8'h80
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 fs,
    input  wire ip_tx_pkg::ip_len_t   data_len,
    input  wire ip_tx_pkg::ip_addr_t  src_ip_addr,
    input  wire ip_tx_pkg::ip_addr_t  dst_ip_addr,
    input  wire ip_tx_pkg::ip_proto_t ip_mode,
    output logic                      fd,
    output ip_tx_pkg::ip_byte_t       ip_txd,
    output logic                      ip_txd_en
);

    ip_tx_pkg::ip_hdr_fields_t fields;
    ip_tx_pkg::ip_len_t        ident;
    ip_tx_pkg::ip_len_t        csum;
    ip_tx_pkg::hdr_idx_t       hdr_idx;
    ip_tx_pkg::ip_byte_t       udp_byte;
    ip_tx_pkg::ip_byte_t       icmp_byte;
    ip_tx_pkg::ip_byte_t       pay_byte;
    logic csum_start;
    logic csum_valid;
    logic hdr_en;
    logic fs_udp;
    logic fs_icmp;
    logic fd_udp;
    logic fd_icmp;
    logic udp_valid;
    logic icmp_valid;
    logic pay_valid;

    assign fields = '{total_len: data_len, ident: ident, proto: ip_mode,
                      src: src_ip_addr, dst: dst_ip_addr};

    // idle source drives zeros, so a plain OR merges them.
    assign pay_byte  = udp_byte | icmp_byte;
    assign pay_valid = udp_valid | icmp_valid;

    ip_tx_ctrl u_ctrl (
        .clk(clk), .rst(rst), .fs(fs), .proto(ip_mode),
        .fd_udp(fd_udp), .fd_icmp(fd_icmp), .csum_valid(csum_valid),
        .fd(fd), .ident(ident), .csum_start(csum_start), .hdr_en(hdr_en),
        .hdr_idx(hdr_idx), .fs_udp(fs_udp), .fs_icmp(fs_icmp)
    );

    ip_hdr_checksum u_csum (
        .clk(clk), .rst(rst), .start(csum_start), .fields(fields),
        .csum(csum), .valid(csum_valid)
    );

    ip_tx_byte_mux u_mux (
        .clk(clk), .rst(rst), .hdr_en(hdr_en), .hdr_idx(hdr_idx),
        .fields(fields), .csum(csum), .pay_valid(pay_valid), .pay_byte(pay_byte),
        .ip_txd(ip_txd), .ip_txd_en(ip_txd_en)
    );

    ip_payload_gen #(.PATTERN_BASE(UDP_PATTERN)) u_udp (
        .clk(clk), .rst(rst), .fs(fs_udp), .total_len(data_len),
        .fd(fd_udp), .pay_byte(udp_byte), .pay_valid(udp_valid)
    );

    ip_payload_gen #(.PATTERN_BASE(ICMP_PATTERN)) u_icmp (
        .clk(clk), .rst(rst), .fs(fs_icmp), .total_len(data_len),
        .fd(fd_icmp), .pay_byte(icmp_byte), .pay_valid(icmp_valid)
    );

endmodule

`default_nettype wire

/* verification/ip_tx_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ip_tx_tb;

    localparam int     CLK_PERIOD  = 100;
    localparam int     NUM_REQ     = 40;
    localparam int     MAX_LEN     = 83;
    localparam int     SLACK       = 60;   // checksum, handshake and idle cycles.
    localparam longint WATCHDOG_NS = longint'(NUM_REQ * (MAX_LEN + SLACK) + 20) * CLK_PERIOD;

    localparam logic [7:0] PROTO_UDP  = 8'h11;
    localparam logic [7:0] PROTO_ICMP = 8'h01;

    logic        clk = 1'b0;
    logic        rst;
    logic        fs;
    logic [15:0] data_len;
    logic [31:0] src_ip_addr;
    logic [31:0] dst_ip_addr;
    logic [7:0]  ip_mode;
    logic        fd;
    logic [7:0]  ip_txd;
    logic        ip_txd_en;

    logic [31:0] lfsr;
    logic [7:0]  rx_q[$];      // bytes of the current datagram.
    int          run_count;    // ip_txd_en bursts in the current datagram.
    logic        en_prev = 1'b0;
    logic [15:0] exp_ident;
    int          value_errors;
    int          protocol_errors;
    int          sent;
    int          rejected;
    logic [7:0]  illegal_list [4] = '{8'h06, 8'h00, 8'hFF, 8'h10};

    ip_tx_top #(.UDP_PATTERN(8'h00), .ICMP_PATTERN(8'h80)) DUT (
        .clk(clk), .rst(rst), .fs(fs), .data_len(data_len),
        .src_ip_addr(src_ip_addr), .dst_ip_addr(dst_ip_addr), .ip_mode(ip_mode),
        .fd(fd), .ip_txd(ip_txd), .ip_txd_en(ip_txd_en)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // ones-complement sum of the ten header words, carries folded.
    function automatic logic [15:0] fold_sum(input logic [159:0] h);
        logic [31:0] acc;
        int i;
        acc = '0;
        for (i = 0; i < 10; i++) begin
            acc = acc + {16'd0, h[159 - 16 * i -: 16]};
        end
        while (acc[31:16] != 16'd0) begin
            acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        end
        return acc[15:0];
    endfunction

    function automatic logic [159:0] expected_header(input logic [15:0] len,
            input logic [15:0] id, input logic [7:0] proto,
            input logic [31:0] src, input logic [31:0] dst);
        logic [159:0] h;
        h = {8'h45, 8'h00, len, id, 16'h4000, 8'h80, proto, 16'h0000, src, dst};
        h[79:64] = ~fold_sum(h);
        return h;
    endfunction

    task automatic flag_mismatch(input string msg);
        value_errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (ip_txd_en) begin
            rx_q.push_back(ip_txd);
            if (!en_prev) run_count++;
        end
        en_prev = ip_txd_en;
    end

    a_fd_needs_fs: assert property (@(posedge clk) disable iff (rst) fd |-> fs)
        else begin
            protocol_errors++;
            $display("[FAIL] %0t: fd high while fs is low", $time);
        end

    a_fd_holds: assert property (@(posedge clk) disable iff (rst) (fd && fs) |=> (fd || !fs))
        else begin
            protocol_errors++;
            $display("[FAIL] %0t: fd dropped before fs fell", $time);
        end

    a_en_in_request: assert property (@(posedge clk) disable iff (rst) ip_txd_en |-> fs)
        else begin
            protocol_errors++;
            $display("[FAIL] %0t: ip_txd_en high outside a request", $time);
        end

    task automatic check_datagram(input logic [7:0] proto);
        logic [159:0] exp_h;
        logic [159:0] got_h;
        logic [7:0]   base;
        int i;
        if (proto != PROTO_UDP && proto != PROTO_ICMP) begin
            assert (rx_q.size() == 0)
                else flag_mismatch($sformatf("protocol %h sent %0d bytes", proto, rx_q.size()));
            rejected++;
        end else begin
            exp_h = expected_header(data_len, exp_ident, proto, src_ip_addr, dst_ip_addr);
            got_h = '0;
            assert (rx_q.size() == int'(data_len))
                else flag_mismatch($sformatf("got %0d bytes, expected %0d",
                                             rx_q.size(), data_len));
            assert (run_count == 1)
                else flag_mismatch($sformatf("ip_txd_en came in %0d bursts", run_count));
            for (i = 0; i < 20 && i < rx_q.size(); i++) begin
                got_h[159 - 8 * i -: 8] = rx_q[i];
            end
            assert (got_h[127:112] == exp_ident)
                else flag_mismatch($sformatf("ident %h, expected %h", got_h[127:112], exp_ident));
            for (i = 0; i < 20; i++) begin
                assert (got_h[159 - 8 * i -: 8] == exp_h[159 - 8 * i -: 8])
                    else flag_mismatch($sformatf("header byte %0d is %h, expected %h", i,
                                                 got_h[159 - 8 * i -: 8],
                                                 exp_h[159 - 8 * i -: 8]));
            end
            assert (fold_sum(got_h) == 16'hFFFF)
                else flag_mismatch($sformatf("header sum %h", fold_sum(got_h)));
            base = (proto == PROTO_UDP) ? 8'h00 : 8'h80;
            for (i = 20; i < rx_q.size(); i++) begin
                assert (rx_q[i] == 8'(base + i - 20))
                    else flag_mismatch($sformatf("payload byte %0d is %h, expected %h",
                                                 i - 20, rx_q[i], 8'(base + i - 20)));
            end
            exp_ident++;
            sent++;
        end
    endtask

    // entered and left on a falling edge.
    task automatic run_request(input int n);
        logic [31:0] r;
        logic [7:0]  proto;
        take_bits(1, r);
        proto = r[0] ? PROTO_ICMP : PROTO_UDP;
        if (n % 8 == 7) proto = illegal_list[(n / 8) % 4];
        take_bits(6, r);
        data_len = 16'd20 + {10'd0, r[5:0]};
        if (n == 1) begin
            proto    = PROTO_ICMP;   // header-only datagram.
            data_len = 16'd20;
        end
        take_bits(32, r);
        src_ip_addr = r;
        take_bits(32, r);
        dst_ip_addr = r;
        ip_mode     = proto;
        rx_q.delete();
        run_count = 0;
        fs = 1'b1;
        do @(negedge clk); while (!fd);
        repeat (2) @(negedge clk);   // fd has to hold while fs stays up.
        fs = 1'b0;
        repeat (4) @(negedge clk);
        check_datagram(proto);
    endtask

    initial begin
        int n;
        rst             = 1'b1;
        fs              = 1'b0;
        data_len        = '0;
        src_ip_addr     = '0;
        dst_ip_addr     = '0;
        ip_mode         = '0;
        lfsr            = 32'h444;
        exp_ident       = '0;
        value_errors    = 0;
        protocol_errors = 0;
        sent            = 0;
        rejected        = 0;
        run_count       = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        for (n = 0; n < NUM_REQ; n++) begin
            run_request(n);
        end
        $display("done: %0d sent, %0d rejected, %0d value errors, %0d protocol errors",
                 sent, rejected, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the requests did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/ip_tx_pkg.sv
source/ip_tx_ctrl.sv
source/ip_hdr_checksum.sv
source/ip_tx_byte_mux.sv
source/ip_payload_gen.sv
source/ip_tx_top.sv
verification/ip_tx_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= ip_tx_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
